//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_system_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
design/cache_pkg.sv
design/mem_pkg.sv
design/bank_if.sv
design/bank_dispatch.sv
design/mem_bank.sv
design/bank_collect.sv
design/four_bank_mem.sv
design/cache_array.sv
design/mem_system.sv
verification/mem_system_props.sv
verification/mem_system_tb.sv

//--- design/bank_collect.sv
// Read return collector registering the word of the bank showing rvalid
`default_nettype none
`timescale 1ns/1ps

module bank_collect (
   input  logic             clk,
   input  logic             reset,
   bank_if.collect          banks [0:mem_pkg::BANK_COUNT-1],
   output cache_pkg::word_t data_out,
   output logic             data_valid
);
   import mem_pkg::*;

   logic [BANK_COUNT-1:0] rvalid_vec;
   cache_pkg::word_t      rdata_arr [BANK_COUNT];
   cache_pkg::word_t      pick_data;

   for (genvar i = 0; i < BANK_COUNT; i++) begin : g_ret
      assign rvalid_vec[i] = banks[i].rvalid;
      assign rdata_arr[i]  = banks[i].rdata;
   end

   // At most one bank returns per cycle
   always_comb begin
      pick_data = '0;
      for (int i = 0; i < BANK_COUNT; i++) begin
         if (rvalid_vec[i])
            pick_data = rdata_arr[i];
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         data_valid <= 1'b0;
      else
         data_valid <= |rvalid_vec;
   end

   always_ff @(posedge clk) begin
      if (|rvalid_vec)
         data_out <= pick_data;
   end

endmodule

`default_nettype wire

//--- design/bank_dispatch.sv
// Bank request dispatcher with per-bank hold registers and stall decode
`default_nettype none
`timescale 1ns/1ps

module bank_dispatch (
   input  logic             clk,
   input  logic             reset,
   input  logic             rd,
   input  logic             wr,
   input  cache_pkg::addr_t addr,
   input  cache_pkg::word_t data_in,
   output logic             stall,
   bank_if.dispatch         banks [0:mem_pkg::BANK_COUNT-1]
);
   import mem_pkg::*;

   bank_sel_t               sel;
   bank_addr_t              word_addr;
   logic                    req;
   logic                    take;
   logic [BANK_COUNT-1:0]   busy_vec;
   // Last request seen by each bank, keeps idle bank inputs quiet
   logic [BANK_COUNT-1:0]   hold_wr;
   bank_addr_t              hold_addr [BANK_COUNT];
   cache_pkg::word_t        hold_data [BANK_COUNT];

   // Byte address 2:1 picks the bank, upper bits address inside it
   assign sel       = addr[2:1];
   assign word_addr = addr[15:3];
   assign req       = rd | wr;
   assign stall     = busy_vec[sel];
   assign take      = req & ~stall;

   always_ff @(posedge clk) begin
      if (reset) begin
         hold_wr <= '0;
      end else if (take) begin
         hold_wr[sel] <= wr;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         hold_addr[sel] <= word_addr;
         hold_data[sel] <= data_in;
      end
   end

   for (genvar i = 0; i < BANK_COUNT; i++) begin : g_port
      logic pick;
      assign pick          = (sel == bank_sel_t'(i));
      assign busy_vec[i]   = banks[i].busy;
      // Only the addressed bank gets an enable
      assign banks[i].en    = pick & take;
      assign banks[i].wr    = pick ? wr        : hold_wr[i];
      assign banks[i].addr  = pick ? word_addr : hold_addr[i];
      assign banks[i].wdata = pick ? data_in   : hold_data[i];
   end

endmodule

`default_nettype wire

//--- design/bank_if.sv
// Per-bank request and return interface with dispatch, bank and collect modports
`default_nettype none
`timescale 1ns/1ps

interface bank_if;
   import mem_pkg::*;
   import cache_pkg::*;

   // Request side, driven by the dispatcher
   logic       en;
   logic       wr;
   bank_addr_t addr;
   word_t      wdata;

   // Bank side
   logic       busy;
   word_t      rdata;
   logic       rvalid;

   modport dispatch (output en, wr, addr, wdata, input busy);
   modport bank     (input en, wr, addr, wdata, output busy, rdata, rvalid);
   // Collector only sees returning reads
   modport collect  (input rdata, rvalid);

endinterface

`default_nettype wire

//--- design/cache_array.sv
// Direct-mapped tag, valid, dirty and data storage with tag compare
`default_nettype none
`timescale 1ns/1ps

module cache_array (
   input  logic                  clk,
   input  logic                  reset,
   input  cache_pkg::index_t     index,
   input  cache_pkg::word_sel_t  word_sel,
   input  cache_pkg::tag_t       tag_in,
   input  logic                  write_word,
   input  cache_pkg::word_t      data_in,
   input  logic                  set_dirty,
   input  logic                  install,
   output logic                  hit,
   output logic                  dirty,
   output cache_pkg::tag_t       tag_out,
   output cache_pkg::word_t      data_out
);
   import cache_pkg::*;

   tag_t                  tags  [LINE_COUNT];
   word_t                 lines [LINE_COUNT][LINE_WORDS];
   logic [LINE_COUNT-1:0] valid_q;
   logic [LINE_COUNT-1:0] dirty_q;

   ////////////////////////////////////////////////////////////////////////////
   // Line state
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else begin
         // Fresh line from memory is clean
         if (install) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
         end
         if (set_dirty)
            dirty_q[index] <= 1'b1;
      end
   end

   // Tag and data storage
   always_ff @(posedge clk) begin
      if (install)
         tags[index] <= tag_in;
      if (write_word)
         lines[index][word_sel] <= data_in;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////////////////////////////////////////

   assign tag_out  = tags[index];
   assign data_out = lines[index][word_sel];
   assign hit      = valid_q[index] && (tag_out == tag_in);
   // Invalid lines never report dirty
   assign dirty    = valid_q[index] & dirty_q[index];

endmodule

`default_nettype wire

//--- design/cache_pkg.sv
// Cache word, address field types, line geometry and controller states
`default_nettype none

package cache_pkg;

   // Processor data word and byte address
   typedef logic [15:0] word_t;
   typedef logic [15:0] addr_t;

   // Tag from address bits 15 to 11
   typedef logic [4:0]  tag_t;
   // Line index from bits 10 to 3
   typedef logic [7:0]  index_t;
   // Word within the line from bits 2 to 1
   typedef logic [1:0]  word_sel_t;

   localparam int LINE_WORDS = 4;
   localparam int LINE_COUNT = 2 ** $bits(index_t);

   // Miss handling controller
   typedef enum logic [2:0] {
      IDLE,          // Waiting for rd or wr
      COMPARE,       // Tag lookup on the registered address
      HIT_DONE,      // Hit completes, done and cache_hit high
      WRITE_BACK,    // Dirty victim words out to memory
      FILL,          // Line refill from the banks
      FINISH         // Miss completes with the refilled line
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- design/four_bank_mem.sv
// Four-bank interleaved memory built from dispatcher, banks and collector
`default_nettype none
`timescale 1ns/1ps

module four_bank_mem (
   input  logic             clk,
   input  logic             reset,
   input  logic             rd,
   input  logic             wr,
   input  cache_pkg::addr_t addr,
   input  cache_pkg::word_t data_in,
   output cache_pkg::word_t data_out,
   output logic             data_valid,
   output logic             stall
);
   import mem_pkg::*;

   // One request and return bundle per bank
   bank_if bus [0:BANK_COUNT-1] ();

   bank_dispatch u_dispatch (
      .clk     (clk),
      .reset   (reset),
      .rd      (rd),
      .wr      (wr),
      .addr    (addr),
      .data_in (data_in),
      .stall   (stall),
      .banks   (bus)
   );

   for (genvar i = 0; i < BANK_COUNT; i++) begin : g_bank
      mem_bank u_bank (
         .clk   (clk),
         .reset (reset),
         .port  (bus[i])
      );
   end

   // Returns arrive in issue order
   bank_collect u_collect (
      .clk        (clk),
      .reset      (reset),
      .banks      (bus),
      .data_out   (data_out),
      .data_valid (data_valid)
   );

endmodule

`default_nettype wire

//--- design/mem_bank.sv
// Single memory bank with fixed-latency read pipeline and busy countdown
`default_nettype none
`timescale 1ns/1ps

module mem_bank (
   input  logic clk,
   input  logic reset,
   bank_if.bank port
);
   import mem_pkg::*;

   cache_pkg::word_t        storage [BANK_WORDS];
   cache_pkg::word_t        rd_pipe [BANK_LATENCY];
   logic [BANK_LATENCY-1:0] vld_pipe;
   lat_cnt_t                busy_cnt;
   logic                    accept;

   // Memory starts out zeroed
   initial begin
      for (int i = 0; i < BANK_WORDS; i++) begin
         storage[i] = '0;
      end
   end

   assign accept = port.en & ~port.busy;

   // Writes land at the accepting edge
   always_ff @(posedge clk) begin
      if (accept && port.wr) begin
         storage[port.addr] <= port.wdata;
      end
   end

   // Read data shift, several reads may be in flight
   always_ff @(posedge clk) begin
      rd_pipe[0] <= storage[port.addr];
      for (int i = 1; i < BANK_LATENCY; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         vld_pipe <= '0;
         busy_cnt <= '0;
      end else begin
         vld_pipe <= {vld_pipe[BANK_LATENCY-2:0], accept & ~port.wr};
         // Reload on accept, else count down to idle
         if (accept)
            busy_cnt <= lat_cnt_t'(BANK_LATENCY);
         else if (busy_cnt != '0)
            busy_cnt <= busy_cnt - 1'b1;
      end
   end

   assign port.busy   = (busy_cnt != '0);
   assign port.rdata  = rd_pipe[BANK_LATENCY-1];
   assign port.rvalid = vld_pipe[BANK_LATENCY-1];

endmodule

`default_nettype wire

//--- design/mem_pkg.sv
// Bank select and bank address types, bank depth and latencies
`default_nettype none

package mem_pkg;

   // Bank number is word address bits 1..0
   typedef logic [1:0]  bank_sel_t;
   // Word address inside one bank
   typedef logic [12:0] bank_addr_t;

   localparam int BANK_COUNT = 4;
   localparam int BANK_WORDS = 2 ** $bits(bank_addr_t);

   // Accepting edge to bank rvalid
   localparam int BANK_LATENCY = 3;
   // Bank latency plus the collector register
   localparam int MEM_READ_LATENCY = BANK_LATENCY + 1;

   // Busy countdown inside a bank
   typedef logic [$clog2(BANK_LATENCY + 1)-1:0] lat_cnt_t;

endpackage

`default_nettype wire

//--- design/mem_system.sv
// Cached data memory top with miss FSM, request registers and word counters
`default_nettype none
`timescale 1ns/1ps

module mem_system (
   input  logic             clk,
   input  logic             reset,
   input  cache_pkg::addr_t addr,
   input  cache_pkg::word_t data_in,
   input  logic             rd,
   input  logic             wr,
   output cache_pkg::word_t data_out,
   output logic             done,
   output logic             stall,
   output logic             cache_hit,
   output logic             err
);
   import cache_pkg::*;

   ctrl_state_t                 state;
   // Request captured at accept
   addr_t                       req_addr;
   word_t                       req_data;
   logic                        req_wr;
   logic                        req;
   logic                        illegal;
   logic                        ready;
   logic                        accept;
   // Issue counter needs to reach LINE_WORDS in fill
   logic [$clog2(LINE_WORDS):0] iss_cnt;
   word_sel_t                   ret_cnt;
   logic                        issue_ok;
   // Array side
   tag_t                        arr_tag_out;
   word_t                       arr_data_out;
   word_t                       arr_data_in;
   word_sel_t                   arr_word_sel;
   logic                        arr_hit;
   logic                        arr_dirty;
   logic                        arr_write;
   logic                        arr_set_dirty;
   logic                        arr_install;
   // Memory side
   addr_t                       mem_addr;
   word_t                       mem_data_out;
   logic                        mem_rd;
   logic                        mem_wr;
   logic                        mem_valid;
   logic                        mem_stall;

   ////////////////////////////////////////////////////////////////////////////
   // Processor side decode
   ////////////////////////////////////////////////////////////////////////////

   assign req     = rd | wr;
   // Both strobes or an odd byte address
   assign illegal = (rd & wr) | addr[0];
   assign done    = (state == HIT_DONE) || (state == FINISH);
   // Done cycle also takes the next request
   assign ready   = (state == IDLE) || done;
   assign accept  = ready & req & ~illegal;

   assign stall     = ~ready;
   assign cache_hit = (state == HIT_DONE);
   assign data_out  = req_wr ? req_data : arr_data_out;

   // Array hookup, word select follows the active counter
   always_comb begin
      case (state)
         WRITE_BACK: arr_word_sel = iss_cnt[1:0];
         FILL:       arr_word_sel = ret_cnt;
         default:    arr_word_sel = req_addr[2:1];
      endcase
   end

   assign arr_data_in   = (state == FILL) ? mem_data_out : req_data;
   assign arr_set_dirty = done & req_wr;
   assign arr_write     = ((state == FILL) & mem_valid) | arr_set_dirty;
   assign arr_install   = (state == FILL) && mem_valid && (ret_cnt == LINE_WORDS - 1);

   // Victim lines go back under their own tag
   assign mem_wr   = (state == WRITE_BACK);
   assign mem_rd   = (state == FILL) && (iss_cnt < LINE_WORDS);
   assign mem_addr = {mem_wr ? arr_tag_out : req_addr[15:11], req_addr[10:3],
                      iss_cnt[1:0], 1'b0};
   assign issue_ok = (mem_rd | mem_wr) & ~mem_stall;

   ////////////////////////////////////////////////////////////////////////////
   // Miss handling FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= IDLE;
         req_wr  <= 1'b0;
         iss_cnt <= '0;
         ret_cnt <= '0;
         err     <= 1'b0;
      end else begin
         err <= ready & req & illegal;
         if (issue_ok)
            iss_cnt <= iss_cnt + 1'b1;
         // Wraps back to zero after the last word
         if ((state == FILL) && mem_valid)
            ret_cnt <= ret_cnt + 1'b1;
         case (state)
            IDLE, HIT_DONE, FINISH: begin
               state <= accept ? COMPARE : IDLE;
               if (accept)
                  req_wr <= wr;
            end
            COMPARE:
               state <= arr_hit ? HIT_DONE : (arr_dirty ? WRITE_BACK : FILL);
            WRITE_BACK: begin
               if (issue_ok && (iss_cnt == LINE_WORDS - 1)) begin
                  state   <= FILL;
                  iss_cnt <= '0;
               end
            end
            FILL: begin
               if (arr_install) begin
                  state   <= FINISH;
                  iss_cnt <= '0;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
      end
   end

   cache_array u_array (
      .clk        (clk),
      .reset      (reset),
      .index      (req_addr[10:3]),
      .word_sel   (arr_word_sel),
      .tag_in     (req_addr[15:11]),
      .write_word (arr_write),
      .data_in    (arr_data_in),
      .set_dirty  (arr_set_dirty),
      .install    (arr_install),
      .hit        (arr_hit),
      .dirty      (arr_dirty),
      .tag_out    (arr_tag_out),
      .data_out   (arr_data_out)
   );

   four_bank_mem u_mem (
      .clk        (clk),
      .reset      (reset),
      .rd         (mem_rd),
      .wr         (mem_wr),
      .addr       (mem_addr),
      .data_in    (arr_data_out),
      .data_out   (mem_data_out),
      .data_valid (mem_valid),
      .stall      (mem_stall)
   );

endmodule

`default_nettype wire

//--- verification/mem_system_props.sv
// Concurrent checks on done, err and stall of the cached memory top, with bind
`default_nettype none
`timescale 1ns/1ps

module mem_system_props (
   input logic clk,
   input logic reset,
   input logic rd,
   input logic wr,
   input logic done,
   input logic stall,
   input logic err
);

   // Completion and illegal request never coincide
   a_done_err: assert property (@(posedge clk) disable iff (reset) !(done && err))
      else $error("done and err high in the same cycle");

   // Single cycle completion pulse
   a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
      else $error("done held longer than one cycle");

   // Done closes a stalled access with stall already low
   a_done_stall: assert property (@(posedge clk) disable iff (reset)
                                  done |-> (!stall && $past(stall)))
      else $error("done with stall high or without a stalled cycle before it");

   // Stall only follows an accepted request
   a_stall_req: assert property (@(posedge clk) disable iff (reset)
                                 $rose(stall) |-> $past(rd || wr))
      else $error("stall rose without a request");

endmodule

bind mem_system mem_system_props u_props (
   .clk   (clk),
   .reset (reset),
   .rd    (rd),
   .wr    (wr),
   .done  (done),
   .stall (stall),
   .err   (err)
);

`default_nettype wire

//--- verification/mem_system_tb.sv
// Testbench for the cached memory top with reference model, checker and watchdog
`default_nettype none
`timescale 1ns/1ps

module mem_system_tb;
   import cache_pkg::*;

   localparam int CLK_PERIOD     = 4;
   localparam int RESET_CYCLES   = 16;
   localparam int RANDOM_COUNT   = 300;
   // Worst case cycle budget per request
   localparam int REQ_LIMIT      = 400;
   localparam int CYCLES_PER_REQ = 60;
   localparam int WATCHDOG_NS    = (RESET_CYCLES + REQ_LIMIT * CYCLES_PER_REQ) * CLK_PERIOD;

   logic  clk;
   logic  reset;
   addr_t addr;
   word_t data_in;
   logic  rd;
   logic  wr;
   word_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   // Reference state
   word_t mem_model [addr_t];
   tag_t  tag_model [LINE_COUNT];
   logic  valid_model [LINE_COUNT];

   // Outstanding expectations with one entry per request
   word_t  exp_word_q [$];
   logic   exp_hit_q [$];
   logic   exp_err_q [$];
   int     issue_q [$];
   int     sent_count;
   int     resp_count;
   int     cycle_count;
   int     error_count;
   integer seed;

   mem_system UUT (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Edge count for latency checks
   always @(posedge clk) cycle_count <= cycle_count + 1;

   ////////////////////////////////////////////////////////////////////////////
   // Reference model and helpers
   ////////////////////////////////////////////////////////////////////////////

   // Untouched words read as zero
   function automatic void predict(input logic is_wr, input addr_t a, input word_t d,
                                   output word_t exp_word, output logic exp_hit);
      index_t idx;
      tag_t   tg;
      idx = a[10:3];
      tg  = a[15:11];
      exp_hit          = valid_model[idx] && (tag_model[idx] == tg);
      valid_model[idx] = 1'b1;
      tag_model[idx]   = tg;
      if (is_wr) begin
         mem_model[a] = d;
         exp_word     = d;
      end else begin
         exp_word = mem_model.exists(a) ? mem_model[a] : '0;
      end
   endfunction

   task automatic abort_run(input string why);
      error_count++;
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1);
   endtask

   // Request held for one cycle and then waits for its response
   task automatic access(input logic do_rd, input logic do_wr, input addr_t a, input word_t d);
      word_t ew;
      logic  eh;
      logic  ee;
      @(negedge clk);
      ee = (do_rd && do_wr) || a[0];
      ew = '0;
      eh = 1'b0;
      // Illegal requests leave the model untouched
      if (!ee)
         predict(do_wr, a, d, ew, eh);
      exp_word_q.push_back(ew);
      exp_hit_q.push_back(eh);
      exp_err_q.push_back(ee);
      issue_q.push_back(cycle_count);
      rd      = do_rd;
      wr      = do_wr;
      addr    = a;
      data_in = d;
      sent_count++;
      @(negedge clk);
      rd = 1'b0;
      wr = 1'b0;
      wait (resp_count == sent_count);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Checker
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      word_t ew;
      logic  eh;
      logic  ee;
      int    ic;
      logic  busy_exp;
      forever begin
         @(negedge clk);
         // Stall from the cycle after a legal accept up to its done cycle
         if (!reset) begin
            if (done || err)
               busy_exp = 1'b0;
            else
               busy_exp = (issue_q.size() > 0) && !exp_err_q[0] &&
                          (cycle_count > issue_q[0]);
            assert (stall == busy_exp)
               else abort_run($sformatf("ERR %0t: stall %b, expected %b",
                                        $time, stall, busy_exp));
         end
         if (!reset && (done || err)) begin
            assert (exp_err_q.size() > 0)
               else abort_run("A response arrived with no request outstanding");
            ew = exp_word_q.pop_front();
            eh = exp_hit_q.pop_front();
            ee = exp_err_q.pop_front();
            ic = issue_q.pop_front();
            assert (!(done && err))
               else abort_run($sformatf("ERR %0t: done and err high together", $time));
            assert (err == ee)
               else abort_run($sformatf("ERR %0t: err %b, expected %b", $time, err, ee));
            if (!ee) begin
               assert (data_out == ew)
                  else abort_run($sformatf("ERR %0t: data_out %h, expected %h",
                                           $time, data_out, ew));
               assert (cache_hit == eh)
                  else abort_run($sformatf("ERR %0t: cache_hit %b, expected %b",
                                           $time, cache_hit, eh));
               // Hit path runs through COMPARE into HIT_DONE
               if (eh) begin
                  assert (cycle_count - ic == 2)
                     else abort_run($sformatf("ERR %0t: hit took %0d cycles, expected 2",
                                              $time, cycle_count - ic));
               end
            end
            resp_count++;
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      abort_run("Timeout: the DUT stopped answering requests");
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] r;
      addr_t       a;
      rd          = 1'b0;
      wr          = 1'b0;
      addr        = '0;
      data_in     = '0;
      reset       = 1'b1;
      seed        = 69;
      sent_count  = 0;
      resp_count  = 0;
      cycle_count = 0;
      error_count = 0;
      for (int i = 0; i < LINE_COUNT; i++) begin
         valid_model[i] = 1'b0;
         tag_model[i]   = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Untouched line misses and returns zero
      access(1'b1, 1'b0, 16'h0100, '0);
      // Write allocate then hit on the read
      access(1'b0, 1'b1, 16'h0204, 16'hbeef);
      access(1'b1, 1'b0, 16'h0204, '0);
      // Index 9 with tags 1 and 3 so the dirty victim goes back
      access(1'b0, 1'b1, 16'h0848, 16'h1234);
      access(1'b0, 1'b1, 16'h1848, 16'h5678);
      access(1'b1, 1'b0, 16'h0848, '0);
      access(1'b1, 1'b0, 16'h1848, '0);
      // Both strobes and then odd addresses
      access(1'b1, 1'b1, 16'h0204, 16'hdead);
      access(1'b1, 1'b0, 16'h0204, '0);
      access(1'b1, 1'b0, 16'h0849, '0);
      access(1'b0, 1'b1, 16'h0849, 16'hffff);
      access(1'b1, 1'b0, 16'h0848, '0);

      // Four tags by four indices over any word of the line
      for (int n = 0; n < RANDOM_COUNT; n++) begin
         r = $random(seed);
         a = {r[1:0], 3'b101, 6'd0, r[3:2], r[5:4], 1'b0};
         access(~r[6], r[6], a, r[31:16]);
      end

      repeat (4) @(negedge clk);
      if (error_count == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire
